/* common/beats_pkg.sv */
package beats_pkg;

    // --------------------
    // Widths
    // --------------------

    // Burst length field, a burst carries len+1 beats
    localparam int LEN_WIDTH = 8;

    // Byte address on the command and AR ports
    localparam int ADDR_WIDTH = 32;

    // --------------------
    // Command opcodes
    // --------------------

    // READ fetches a burst into the beat buffer
    // FENCE waits for every earlier beat to drain
    typedef enum logic [0:0] {
        CMD_READ  = 1'b0,
        CMD_FENCE = 1'b1
    } cmd_op_e;

    // --------------------
    // Decoder FSM states
    // --------------------

    // IDLE        ready for the next command
    // WAIT_SPACE  asking the allocator for len+1 beats
    // ISSUE       AR presented, waiting for ar_ready
    // FENCE_WAIT  parked until nothing is reserved
    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        WAIT_SPACE = 2'd1,
        ISSUE      = 2'd2,
        FENCE_WAIT = 2'd3
    } dec_state_e;

endpackage : beats_pkg

/* common/beats_alloc_if.sv */
interface beats_alloc_if #(
    parameter int DEPTH = 512
) ();

    // Space request from the decoder, held until granted
    logic                             alloc_req;
    logic [beats_pkg::LEN_WIDTH:0]    alloc_size;
    // Single cycle grant, only when the whole burst fits
    logic                             alloc_grant;
    // One pulse per beat leaving the buffer
    logic                             drain;
    // Allocator status
    logic [$clog2(DEPTH):0]           space_free;
    logic                             alloc_empty;

    // Decoder side
    modport dec (
        output alloc_req, alloc_size,
        input  alloc_grant, alloc_empty
    );

    // Allocation controller side
    modport alloc (
        input  alloc_req, alloc_size, drain,
        output alloc_grant, space_free, alloc_empty
    );

    // Beat buffer side, only releases space
    modport buffer (
        output drain
    );

endinterface : beats_alloc_if

/* verilog/beats_cmd_decode.sv */
module beats_cmd_decode (
    input  logic                                axi_aclk,
    input  logic                                rst_n,
    // Command input
    input  logic                                cmd_valid,
    output logic                                cmd_ready,
    input  beats_pkg::cmd_op_e                  cmd_op,
    input  logic [beats_pkg::ADDR_WIDTH-1:0]    cmd_addr,
    input  logic [beats_pkg::LEN_WIDTH-1:0]     cmd_len,
    // AR output
    output logic                                ar_valid,
    input  logic                                ar_ready,
    output logic [beats_pkg::ADDR_WIDTH-1:0]    ar_addr,
    output logic [beats_pkg::LEN_WIDTH-1:0]     ar_len,
    // Space reservation
    beats_alloc_if.dec                          alloc
);

    // --------------------
    // State and command latch
    // --------------------
    beats_pkg::dec_state_e                state;
    beats_pkg::dec_state_e                state_next;
    logic [beats_pkg::ADDR_WIDTH-1:0]     addr_q;
    logic [beats_pkg::LEN_WIDTH-1:0]      len_q;
    logic                                 cmd_fire;

    // Only accept in IDLE, one command in flight at a time
    assign cmd_ready = (state == beats_pkg::IDLE);
    assign cmd_fire  = cmd_valid && cmd_ready;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            beats_pkg::IDLE: begin
                if (cmd_fire) begin
                    if (cmd_op == beats_pkg::CMD_FENCE) begin
                        state_next = beats_pkg::FENCE_WAIT;
                    end else begin
                        state_next = beats_pkg::WAIT_SPACE;
                    end
                end
            end
            // Hold the request until the whole burst fits
            beats_pkg::WAIT_SPACE: begin
                if (alloc.alloc_grant) begin
                    state_next = beats_pkg::ISSUE;
                end
            end
            beats_pkg::ISSUE: begin
                if (ar_ready) begin
                    state_next = beats_pkg::IDLE;
                end
            end
            // Every reserved beat has left the buffer
            beats_pkg::FENCE_WAIT: begin
                if (alloc.alloc_empty) begin
                    state_next = beats_pkg::IDLE;
                end
            end
            default: state_next = beats_pkg::IDLE;
        endcase
    end

    always_ff @(posedge axi_aclk) begin
        if (!rst_n) begin
            state <= beats_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Payload captured on command acceptance
    always_ff @(posedge axi_aclk) begin
        if (cmd_fire) begin
            addr_q <= cmd_addr;
            len_q  <= cmd_len;
        end
    end

    // --------------------
    // Outputs
    // --------------------
    // Request len+1 beats, one bit wider to hold 256
    assign alloc.alloc_req  = (state == beats_pkg::WAIT_SPACE);
    assign alloc.alloc_size = (beats_pkg::LEN_WIDTH+1)'(len_q) + 1'b1;

    // AR held stable from grant until accepted
    assign ar_valid = (state == beats_pkg::ISSUE);
    assign ar_addr  = addr_q;
    assign ar_len   = len_q;

endmodule : beats_cmd_decode

/* alloc/alloc_ctrl_beats.sv */
module alloc_ctrl_beats #(
    parameter int DEPTH = 512
) (
    input  logic                    axi_aclk,
    input  logic                    rst_n,
    // Request, grant and drain traffic
    beats_alloc_if.alloc            alloc,
    // Status for the top level
    output logic [$clog2(DEPTH):0]  space_free
);

    // Pointer width, one extra bit so full and empty differ
    localparam int AW = $clog2(DEPTH);

    // --------------------
    // Virtual FIFO pointers
    // --------------------
    // wr_ptr moves by the granted burst size
    // rd_ptr moves by one per drained beat
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] used;
    logic [AW:0] req_size;

    // Requested beats widened to pointer size
    assign req_size = (AW+1)'(alloc.alloc_size);

    // Occupancy, modulo arithmetic handles the wrap
    assign used = wr_ptr - rd_ptr;

    // --------------------
    // Status
    // --------------------
    // Registered pointers so space_free moves a cycle after grant or drain
    assign alloc.space_free  = (AW+1)'(DEPTH) - used;
    assign alloc.alloc_empty = (wr_ptr == rd_ptr);
    assign space_free        = alloc.space_free;

    // Whole burst must fit
    // a partial reservation would let the buffer overflow
    assign alloc.alloc_grant = alloc.alloc_req && (req_size <= alloc.space_free);

    // --------------------
    // Pointer update
    // --------------------
    // Grant and drain may land together
    always_ff @(posedge axi_aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (alloc.alloc_grant) begin
            wr_ptr <= wr_ptr + req_size;
        end
    end

    // Release one beat per drain pulse
    always_ff @(posedge axi_aclk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (alloc.drain) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule : alloc_ctrl_beats

/* buffer/beat_buffer.sv */
module beat_buffer #(
    parameter int DEPTH      = 512,
    parameter int DATA_WIDTH = 64
) (
    input  logic                    axi_aclk,
    input  logic                    rst_n,
    // R beats in
    input  logic                    r_valid,
    output logic                    r_ready,
    input  logic [DATA_WIDTH-1:0]   r_data,
    // Output stream
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [DATA_WIDTH-1:0]   out_data,
    // Releases one reservation per beat out
    beats_alloc_if.buffer           alloc
);

    localparam int AW = $clog2(DEPTH);

    // --------------------
    // Storage
    // --------------------
    logic [DATA_WIDTH-1:0]  mem [DEPTH];
    logic [AW-1:0]          wr_idx;
    logic [AW-1:0]          rd_idx;
    logic [AW:0]            mem_count;

    logic                   r_fire;
    logic                   out_fire;
    logic                   load_out;
    logic                   mem_empty;
    logic                   bypass;
    logic                   mem_wr;
    logic                   mem_rd;

    assign mem_empty = (mem_count == '0);
    // Reservation keeps this high whenever a beat is owed
    assign r_ready   = (mem_count != (AW+1)'(DEPTH));
    assign r_fire    = r_valid && r_ready;
    assign out_fire  = out_valid && out_ready;

    // Output stage can take a new beat
    assign load_out  = !out_valid || out_ready;
    // Empty buffer, incoming beat goes straight to the output stage
    assign bypass    = load_out && mem_empty && r_fire;
    assign mem_wr    = r_fire && !bypass;
    assign mem_rd    = load_out && !mem_empty;

    // One drain pulse per output handshake
    assign alloc.drain = out_fire;

    // Memory write
    always_ff @(posedge axi_aclk) begin
        if (mem_wr) begin
            mem[wr_idx] <= r_data;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge axi_aclk) begin
        if (!rst_n) begin
            wr_idx    <= '0;
            rd_idx    <= '0;
            mem_count <= '0;
        end else begin
            if (mem_wr) begin
                wr_idx <= (wr_idx == AW'(DEPTH-1)) ? '0 : wr_idx + 1'b1;
            end
            if (mem_rd) begin
                rd_idx <= (rd_idx == AW'(DEPTH-1)) ? '0 : rd_idx + 1'b1;
            end
            mem_count <= mem_count + (AW+1)'(mem_wr) - (AW+1)'(mem_rd);
        end
    end

    // --------------------
    // Registered output stage
    // --------------------
    always_ff @(posedge axi_aclk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load_out) begin
            out_valid <= mem_rd || bypass;
        end
    end

    // Oldest stored beat first, else the bypassed one
    always_ff @(posedge axi_aclk) begin
        if (mem_rd) begin
            out_data <= mem[rd_idx];
        end else if (bypass) begin
            out_data <= r_data;
        end
    end

endmodule : beat_buffer

/* verilog/beats_rd_engine.sv */
module beats_rd_engine #(
    parameter int DEPTH      = 512,
    parameter int DATA_WIDTH = 64
) (
    input  logic                                axi_aclk,
    input  logic                                rst_n,
    // Command input
    input  logic                                cmd_valid,
    output logic                                cmd_ready,
    input  beats_pkg::cmd_op_e                  cmd_op,
    input  logic [beats_pkg::ADDR_WIDTH-1:0]    cmd_addr,
    input  logic [beats_pkg::LEN_WIDTH-1:0]     cmd_len,
    // AR channel
    output logic                                ar_valid,
    input  logic                                ar_ready,
    output logic [beats_pkg::ADDR_WIDTH-1:0]    ar_addr,
    output logic [beats_pkg::LEN_WIDTH-1:0]     ar_len,
    // R channel
    input  logic                                r_valid,
    output logic                                r_ready,
    input  logic [DATA_WIDTH-1:0]               r_data,
    // Output stream
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [DATA_WIDTH-1:0]               out_data,
    // Status
    output logic [$clog2(DEPTH):0]              space_free
);

    // --------------------
    // Reservation link
    // --------------------
    beats_alloc_if #(.DEPTH(DEPTH)) u_alloc_if ();

    // Decode, reserve and issue AR
    beats_cmd_decode u_cmd_decode (
        .axi_aclk  (axi_aclk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_len   (cmd_len),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar_addr   (ar_addr),
        .ar_len    (ar_len),
        .alloc     (u_alloc_if.dec)
    );

    // Space accounting
    alloc_ctrl_beats #(
        .DEPTH (DEPTH)
    ) u_alloc_ctrl (
        .axi_aclk   (axi_aclk),
        .rst_n      (rst_n),
        .alloc      (u_alloc_if.alloc),
        .space_free (space_free)
    );

    // Beat storage and output stream
    beat_buffer #(
        .DEPTH      (DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_beat_buffer (
        .axi_aclk  (axi_aclk),
        .rst_n     (rst_n),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r_data    (r_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .alloc     (u_alloc_if.buffer)
    );

endmodule : beats_rd_engine

/* dv/beats_mem_model.sv */
module beats_mem_model #(
    parameter int DATA_WIDTH = 64
) (
    input  logic                                axi_aclk,
    input  logic                                rst_n,
    // AR channel from the DUT
    input  logic                                ar_valid,
    output logic                                ar_ready,
    input  logic [beats_pkg::ADDR_WIDTH-1:0]    ar_addr,
    input  logic [beats_pkg::LEN_WIDTH-1:0]     ar_len,
    // R channel back to the DUT
    output logic                                r_valid,
    input  logic                                r_ready,
    output logic [DATA_WIDTH-1:0]               r_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // Accepted bursts, oldest first
    logic [beats_pkg::ADDR_WIDTH-1:0]   burst_addr [$];
    int                                 burst_beats [$];
    // Beat position inside the oldest burst
    int                                 beat_idx;
    // Running count of R handshakes
    int                                 beats_taken;

    // --------------------
    // Handshake capture
    // --------------------
    always @(posedge axi_aclk) begin
        if (!rst_n) begin
            burst_addr.delete();
            burst_beats.delete();
            beat_idx    = 0;
            beats_taken = 0;
        end else begin
            if (ar_valid && ar_ready) begin
                burst_addr.push_back(ar_addr);
                burst_beats.push_back(int'(ar_len) + 1);
            end
            // Last beat of a burst retires it
            if (r_valid && r_ready) begin
                beats_taken++;
                if (beat_idx + 1 == burst_beats[0]) begin
                    void'(burst_addr.pop_front());
                    void'(burst_beats.pop_front());
                    beat_idx = 0;
                end else begin
                    beat_idx++;
                end
            end
        end
    end

    // --------------------
    // Drive on the falling edge
    // --------------------
    initial begin
        int last_taken;
        last_taken = 0;
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r_data     = '0;
        forever begin
            @(negedge axi_aclk);
            ar_ready = rst_n && ($urandom_range(0, 3) != 0);
            // Hold a beat until it is taken, then maybe leave a gap
            if (!r_valid || beats_taken != last_taken) begin
                r_valid = rst_n && (burst_addr.size() != 0) && ($urandom_range(0, 2) != 0);
                if (burst_addr.size() != 0) begin
                    // Data is the burst address plus the beat index
                    r_data = DATA_WIDTH'(burst_addr[0]) + DATA_WIDTH'(beat_idx);
                end
            end
            last_taken = beats_taken;
        end
    end

endmodule : beats_mem_model

/* dv/tb_beats_rd_engine.sv */
module tb_beats_rd_engine;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH      = 512;
    localparam int DATA_WIDTH = 64;
    localparam int SFW        = $clog2(DEPTH) + 1;
    localparam int NUM_CMDS   = 48;

    logic                               axi_aclk;
    logic                               rst_n;
    logic                               cmd_valid;
    logic                               cmd_ready;
    beats_pkg::cmd_op_e                 cmd_op;
    logic [beats_pkg::ADDR_WIDTH-1:0]   cmd_addr;
    logic [beats_pkg::LEN_WIDTH-1:0]    cmd_len;
    logic                               ar_valid;
    logic                               ar_ready;
    logic [beats_pkg::ADDR_WIDTH-1:0]   ar_addr;
    logic [beats_pkg::LEN_WIDTH-1:0]    ar_len;
    logic                               r_valid;
    logic                               r_ready;
    logic [DATA_WIDTH-1:0]              r_data;
    logic                               out_valid;
    logic                               out_ready;
    logic [DATA_WIDTH-1:0]              out_data;
    logic [SFW-1:0]                     space_free;

    // Scoreboard state
    logic [beats_pkg::ADDR_WIDTH-1:0]   exp_ar_addr [$];
    logic [beats_pkg::LEN_WIDTH-1:0]    exp_ar_len [$];
    logic [DATA_WIDTH-1:0]              exp_data [$];
    int                                 issued_beats;
    int                                 drained_beats;
    // R beats taken by the DUT
    int                                 r_beats;
    // Beats issued before the latest fence
    int                                 fence_mark;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic value_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
        stop_on_error($sformatf("Fail %s expected %0h got %0h", name, expected, actual));
    endtask

    initial begin
        axi_aclk = 1'b0;
        forever #2 axi_aclk = ~axi_aclk;
    end

    beats_rd_engine #(
        .DEPTH      (DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_beats_rd_engine (
        .axi_aclk   (axi_aclk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_len    (cmd_len),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_addr    (ar_addr),
        .ar_len     (ar_len),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r_data     (r_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .space_free (space_free)
    );

    beats_mem_model #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_mem_model (
        .axi_aclk (axi_aclk),
        .rst_n    (rst_n),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_len   (ar_len),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data)
    );

    // --------------------
    // Scoreboard
    // --------------------
    always @(posedge axi_aclk) begin
        if (!rst_n) begin
            exp_ar_addr.delete();
            exp_ar_len.delete();
            exp_data.delete();
            issued_beats  = 0;
            drained_beats = 0;
            r_beats       = 0;
            fence_mark    = 0;
        end else begin
            // Reservation keeps room for every owed beat
            if (r_valid) begin
                assert (r_ready) else value_mismatch("r_ready", 64'(1), 64'(r_ready));
            end
            if (r_valid && r_ready) begin
                r_beats++;
            end
            if (cmd_valid && cmd_ready) begin
                if (cmd_op == beats_pkg::CMD_FENCE) begin
                    fence_mark = issued_beats;
                end else begin
                    exp_ar_addr.push_back(cmd_addr);
                    exp_ar_len.push_back(cmd_len);
                end
            end
            if (ar_valid && ar_ready) begin
                assert (exp_ar_addr.size() != 0)
                    else stop_on_error("AR issued with no READ command pending");
                assert (ar_addr == exp_ar_addr[0])
                    else value_mismatch("ar_addr", 64'(exp_ar_addr[0]), 64'(ar_addr));
                assert (ar_len == exp_ar_len[0])
                    else value_mismatch("ar_len", 64'(exp_ar_len[0]), 64'(ar_len));
                assert (issued_beats - drained_beats + int'(ar_len) + 1 <= DEPTH)
                    else stop_on_error("AR burst would overrun the beat buffer");
                assert (drained_beats >= fence_mark)
                    else stop_on_error("AR issued before the beats ahead of a fence drained");
                // Expected beats follow the address plus index rule
                for (int i = 0; i <= int'(exp_ar_len[0]); i++) begin
                    exp_data.push_back(DATA_WIDTH'(exp_ar_addr[0]) + DATA_WIDTH'(i));
                end
                issued_beats += int'(exp_ar_len[0]) + 1;
                void'(exp_ar_addr.pop_front());
                void'(exp_ar_len.pop_front());
            end
            if (out_valid && out_ready) begin
                assert (exp_data.size() != 0)
                    else stop_on_error("Output beat with no beat expected");
                assert (out_data == exp_data[0])
                    else value_mismatch("out_data", 64'(exp_data[0]), 64'(out_data));
                void'(exp_data.pop_front());
                drained_beats++;
            end
        end
    end

    // Output back-pressure, with occasional long stalls
    initial begin
        int stall_left;
        stall_left = 0;
        out_ready  = 1'b0;
        forever begin
            @(negedge axi_aclk);
            if (stall_left > 0) begin
                out_ready = 1'b0;
                stall_left--;
            end else if ($urandom_range(0, 255) == 0) begin
                out_ready  = 1'b0;
                stall_left = int'($urandom_range(40, 160));
            end else begin
                out_ready = ($urandom_range(0, 3) != 0);
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        void'($urandom(79));
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = beats_pkg::CMD_READ;
        cmd_addr  = '0;
        cmd_len   = '0;
        repeat (8) @(posedge axi_aclk);
        @(negedge axi_aclk);
        rst_n = 1'b1;
        @(negedge axi_aclk);

        // Idle state right after reset
        assert (cmd_ready) else value_mismatch("cmd_ready", 64'(1), 64'(cmd_ready));
        assert (r_ready) else value_mismatch("r_ready", 64'(1), 64'(r_ready));
        assert (!ar_valid) else value_mismatch("ar_valid", 64'(0), 64'(ar_valid));
        assert (!out_valid) else value_mismatch("out_valid", 64'(0), 64'(out_valid));
        assert (space_free == SFW'(DEPTH))
            else value_mismatch("space_free", 64'(DEPTH), 64'(space_free));

        // Mostly short reads, some long bursts, a few fences
        for (int n = 0; n < NUM_CMDS; n++) begin
            cmd_valid = 1'b1;
            cmd_op    = ($urandom_range(0, 7) == 0) ? beats_pkg::CMD_FENCE : beats_pkg::CMD_READ;
            cmd_addr  = $urandom();
            if ($urandom_range(0, 3) == 0) begin
                cmd_len = 8'($urandom_range(128, 255));
            end else begin
                cmd_len = 8'($urandom_range(0, 15));
            end
            do @(posedge axi_aclk); while (!cmd_ready);
            @(negedge axi_aclk);
        end
        cmd_valid = 1'b0;

        // Engine idle, every R beat taken and the output stage empty
        while (!(cmd_ready && exp_ar_addr.size() == 0 && r_beats == issued_beats
                 && !out_valid)) begin
            @(negedge axi_aclk);
        end
        repeat (2) @(negedge axi_aclk);
        assert (drained_beats == issued_beats)
            else value_mismatch("drained_beats", 64'(issued_beats), 64'(drained_beats));
        assert (space_free == SFW'(DEPTH)) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            value_mismatch("space_free", 64'(DEPTH), 64'(space_free));
        end
    end

    // Watchdog sized from the command count
    initial begin
        repeat (NUM_CMDS * 600) @(posedge axi_aclk);
        stop_on_error($sformatf("Timeout, run did not finish within %0d cycles",
                                NUM_CMDS * 600));
    end

endmodule : tb_beats_rd_engine

/* beats_rd_engine.f */
common/beats_pkg.sv
common/beats_alloc_if.sv
verilog/beats_cmd_decode.sv
alloc/alloc_ctrl_beats.sv
buffer/beat_buffer.sv
verilog/beats_rd_engine.sv
dv/beats_mem_model.sv
dv/tb_beats_rd_engine.sv

/* Makefile */
TOP = tb_beats_rd_engine

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, pass on NO ERRORS"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f beats_rd_engine.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
